// ==== verilog.f ====
+incdir+sim
hdl/rv_decode_pkg.sv
hdl/inst_classify.sv
hdl/imm_gen.sv
hdl/operand_select.sv
hdl/decode_stage.sv
sim/tb_decode_stage.sv

// ==== Makefile ====
SIM       := verilator
TOP       := tb_decode_stage
FILELIST  := verilog.f
SIMFLAGS  := --binary --timing --assert
LINTFLAGS := --lint-only -Wall --timing
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== sim/tb_decode_tasks.svh ====
/* decode test tasks and model */

// galois lfsr, one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[62:0], lfsr[0]};
    lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
  end
  return v;
endfunction

// generic field packing, immediates live in the same bit positions
function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd, input opcode_e opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

// format per instruction class, from the isa tables
function automatic inst_fmt_e fmt_of(input inst_op_e op);
  if (op == OP_ILLEGAL) return FMT_NONE;
  if (op inside {OP_LUI, OP_AUIPC}) return FMT_U;
  if (op == OP_JAL) return FMT_J;
  if (op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU}) return FMT_B;
  if (op inside {OP_SB, OP_SH, OP_SW, OP_SD}) return FMT_S;
  if (op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA,
                 OP_OR, OP_AND, OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW}) return FMT_R;
  return FMT_I;
endfunction

// sign-extended immediate, via signed casts
function automatic logic [63:0] imm_of(input inst_fmt_e fmt, input logic [31:0] x);
  case (fmt)
    FMT_I:   return 64'($signed(x[31:20]));
    FMT_S:   return 64'($signed({x[31:25], x[11:7]}));
    FMT_B:   return 64'($signed({x[31], x[7], x[30:25], x[11:8], 1'b0}));
    FMT_U:   return 64'($signed({x[31:12], 12'h000}));
    FMT_J:   return 64'($signed({x[31], x[19:12], x[20], x[30:21], 1'b0}));
    default: return 64'd0;
  endcase
endfunction

task automatic expect_eq(input string tag, input string what,
                         input logic [63:0] got, input logic [63:0] exp);
  checks++;
  if (got !== exp) begin
    $display("** Error @ %0d ns: %s %s is %h, expected %h", $time, tag, what, got, exp);
    errs++;
    test_errs++;
  end
endtask

// bundle loaded at the last edge
task automatic compare_bundle();
  if (pend_act && pend_valid) begin
    expect_eq(pend_tag, "o_valid", 64'(o_valid), 64'd1);
    expect_eq(pend_tag, "o_op", 64'(o_op), 64'(pend_op));
    expect_eq(pend_tag, "o_rd", 64'(o_rd), 64'(pend_rd));
    expect_eq(pend_tag, "o_rd_wen", 64'(o_rd_wen), 64'(pend_wen));
    expect_eq(pend_tag, "o_op1", o_op1, pend_op1);
    expect_eq(pend_tag, "o_op2", o_op2, pend_op2);
    expect_eq(pend_tag, "o_op3", o_op3, pend_op3);
    expect_eq(pend_tag, "o_imm", o_imm, pend_imm);
  end else if (pend_act) begin
    expect_eq("bubble", "o_valid", 64'(o_valid), 64'd0);
    expect_eq("bubble", "o_rd_wen", 64'(o_rd_wen), 64'd0);
  end
endtask

// one instruction, back to back with the previous one
task automatic send(input inst_op_e op, input logic [31:0] inst);
  logic [63:0] pc;
  logic [63:0] d1;
  logic [63:0] d2;
  inst_fmt_e   fmt;
  logic        r1;
  logic        r2;
  logic        wen;
  logic        shift;
  pc    = rand_bits(64) & ~64'h3;
  d1    = rand_bits(64);
  d2    = rand_bits(64);
  fmt   = fmt_of(op);
  r1    = fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
  r2    = fmt inside {FMT_R, FMT_S, FMT_B};
  wen   = fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};
  shift = op inside {OP_SLLI, OP_SRLI, OP_SRAI, OP_SLLIW, OP_SRLIW, OP_SRAIW};
  @(posedge clk);
  i_valid    <= 1'b1;
  i_inst     <= inst;
  i_pc       <= pc;
  i_rs1_data <= d1;
  i_rs2_data <= d2;
  @(negedge clk);
  compare_bundle();
  // read side answers in the same cycle
  expect_eq(op.name(), "o_rs1_ren", 64'(o_rs1_ren), 64'(r1));
  expect_eq(op.name(), "o_rs2_ren", 64'(o_rs2_ren), 64'(r2));
  expect_eq(op.name(), "o_rs1", 64'(o_rs1), r1 ? 64'(inst[19:15]) : 64'd0);
  expect_eq(op.name(), "o_rs2", 64'(o_rs2), r2 ? 64'(inst[24:20]) : 64'd0);
  // what the next edge should load
  pend_act   = 1'b1;
  pend_valid = 1'b1;
  pend_tag   = op.name();
  pend_op    = op;
  pend_wen   = wen;
  pend_rd    = wen ? inst[11:7] : 5'd0;
  pend_imm   = imm_of(fmt, inst);
  pend_op1   = 64'd0;
  pend_op2   = 64'd0;
  pend_op3   = 64'd0;
  case (fmt)
    FMT_R, FMT_S, FMT_B: begin
      pend_op1 = d1;
      pend_op2 = d2;
    end
    FMT_I: begin
      pend_op1 = d1;
      pend_op2 = shift ? {58'd0, inst[25:20]} : pend_imm;
    end
    FMT_U: begin
      pend_op1 = pend_imm;
      pend_op2 = pc;
    end
    FMT_J: begin
      pend_op1 = pc;
      pend_op2 = 64'd4;
    end
    default: ;
  endcase
  // branch and jump targets, jalr link
  if (fmt inside {FMT_B, FMT_J}) begin
    pend_op3 = pc + pend_imm;
  end else if (op == OP_JALR) begin
    pend_op3 = pc + 64'd4;
  end
  test_insts++;
endtask

task automatic send_r(input inst_op_e op, input logic [6:0] f7, input logic [2:0] f3,
                      input opcode_e opc);
  send(op, enc(f7, 5'(rand_bits(5)), 5'(rand_bits(5)), f3, 5'(rand_bits(5)), opc));
endtask

// imm, store, branch, upper and jump forms, all other bits random
task automatic send_f(input inst_op_e op, input logic [2:0] f3, input opcode_e opc);
  send(op, enc(7'(rand_bits(7)), 5'(rand_bits(5)), 5'(rand_bits(5)), f3,
               5'(rand_bits(5)), opc));
endtask

// shift-imm, word forms keep shamt[5] clear
task automatic send_sh(input inst_op_e op, input logic [5:0] f6, input logic [2:0] f3,
                       input opcode_e opc, input logic word);
  logic [5:0] sh;
  sh = 6'(rand_bits(6));
  if (word) sh[5] = 1'b0;
  send(op, enc({f6, sh[5]}, sh[4:0], 5'(rand_bits(5)), f3, 5'(rand_bits(5)), opc));
endtask

// cycle with i_valid low
task automatic idle();
  @(posedge clk);
  i_valid <= 1'b0;
  i_inst  <= 32'(rand_bits(32));
  @(negedge clk);
  compare_bundle();
  pend_act   = 1'b1;
  pend_valid = 1'b0;
endtask

task automatic finish_test(input string name);
  idle();
  $display("%-14s %0d instructions, %0d errors", name, test_insts, test_errs);
  tests_done++;
  test_errs  = 0;
  test_insts = 0;
endtask

// legal add held at the input through reset
task automatic test_reset();
  i_valid <= 1'b1;
  i_inst  <= enc(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd3, OP);
  for (int c = 0; c < 5; c++) begin
    @(posedge clk);
    if (c == 4) begin
      rst     <= 1'b0;
      i_valid <= 1'b0;
    end
    @(negedge clk);
    expect_eq("reset", "o_valid", 64'(o_valid), 64'd0);
    expect_eq("reset", "o_rd_wen", 64'(o_rd_wen), 64'd0);
    expect_eq("reset", "o_op", 64'(o_op), 64'(OP_ILLEGAL));
    expect_eq("reset", "o_op1", o_op1, 64'd0);
  end
  // first cycle out of reset, i_valid low
  @(posedge clk);
  @(negedge clk);
  expect_eq("bubble", "o_valid", 64'(o_valid), 64'd0);
  expect_eq("bubble", "o_rd_wen", 64'(o_rd_wen), 64'd0);
  finish_test("reset");
endtask

task automatic test_reg_ops();
  repeat (2) begin
    send_r(OP_ADD, F7_BASE, F3_ADD, OP);
    send_r(OP_SUB, F7_SUB, F3_ADD, OP);
    send_r(OP_SLL, F7_BASE, F3_SLL, OP);
    send_r(OP_SLT, F7_BASE, F3_SLT, OP);
    send_r(OP_SLTU, F7_BASE, F3_SLTU, OP);
    send_r(OP_XOR, F7_BASE, F3_XOR, OP);
    send_r(OP_SRL, F7_BASE, F3_SRL, OP);
    send_r(OP_SRA, F7_SRA, F3_SRL, OP);
    send_r(OP_OR, F7_BASE, F3_OR, OP);
    send_r(OP_AND, F7_BASE, F3_AND, OP);
    send_r(OP_ADDW, F7_BASE, F3_ADD, OP_32);
    send_r(OP_SUBW, F7_SUB, F3_ADD, OP_32);
    send_r(OP_SLLW, F7_BASE, F3_SLL, OP_32);
    send_r(OP_SRLW, F7_BASE, F3_SRL, OP_32);
    send_r(OP_SRAW, F7_SRA, F3_SRL, OP_32);
  end
  finish_test("reg_ops");
endtask

task automatic test_imm_ops();
  repeat (2) begin
    send_f(OP_LB, F3_LB, LOAD);
    send_f(OP_LH, F3_LH, LOAD);
    send_f(OP_LW, F3_LW, LOAD);
    send_f(OP_LD, F3_LD, LOAD);
    send_f(OP_LBU, F3_LBU, LOAD);
    send_f(OP_LHU, F3_LHU, LOAD);
    send_f(OP_LWU, F3_LWU, LOAD);
    send_f(OP_ADDI, F3_ADD, OP_IMM);
    send_f(OP_SLTI, F3_SLT, OP_IMM);
    send_f(OP_SLTIU, F3_SLTU, OP_IMM);
    send_f(OP_XORI, F3_XOR, OP_IMM);
    send_f(OP_ORI, F3_OR, OP_IMM);
    send_f(OP_ANDI, F3_AND, OP_IMM);
    send_f(OP_ADDIW, F3_ADD, OP_IMM_32);
    send_sh(OP_SLLI, F6_SHIFT, F3_SLL, OP_IMM, 1'b0);
    send_sh(OP_SRLI, F6_SHIFT, F3_SRL, OP_IMM, 1'b0);
    send_sh(OP_SRAI, F6_SRAI, F3_SRL, OP_IMM, 1'b0);
    send_sh(OP_SLLIW, F6_SHIFT, F3_SLL, OP_IMM_32, 1'b1);
    send_sh(OP_SRLIW, F6_SHIFT, F3_SRL, OP_IMM_32, 1'b1);
    send_sh(OP_SRAIW, F6_SRAI, F3_SRL, OP_IMM_32, 1'b1);
  end
  finish_test("imm_ops");
endtask

task automatic test_stores();
  repeat (3) begin
    send_f(OP_SB, F3_SB, STORE);
    send_f(OP_SH, F3_SH, STORE);
    send_f(OP_SW, F3_SW, STORE);
    send_f(OP_SD, F3_SD, STORE);
  end
  finish_test("stores");
endtask

task automatic test_control();
  repeat (2) begin
    send_f(OP_BEQ, F3_BEQ, BRANCH);
    send_f(OP_BNE, F3_BNE, BRANCH);
    send_f(OP_BLT, F3_BLT, BRANCH);
    send_f(OP_BGE, F3_BGE, BRANCH);
    send_f(OP_BLTU, F3_BLTU, BRANCH);
    send_f(OP_BGEU, F3_BGEU, BRANCH);
    send_f(OP_JAL, 3'(rand_bits(3)), JAL);
    send_f(OP_JALR, F3_JALR, JALR);
    send_f(OP_LUI, 3'(rand_bits(3)), LUI);
    send_f(OP_AUIPC, 3'(rand_bits(3)), AUIPC);
  end
  finish_test("control");
endtask

task automatic test_illegal_flow();
  // fence, ecall, unused opcode, mul from the m extension
  send(OP_ILLEGAL, 32'h0ff0_000f);
  send(OP_ILLEGAL, 32'h0000_0073);
  send(OP_ILLEGAL, {25'(rand_bits(25)), 7'h7f});
  send_r(OP_ILLEGAL, 7'b0000001, F3_ADD, OP);
  // mixed run with one bubble in the middle
  for (int k = 0; k < 12; k++) begin
    case (2'(rand_bits(2)))
      2'd0:    send_r(OP_ADD, F7_BASE, F3_ADD, OP);
      2'd1:    send_f(OP_ADDI, F3_ADD, OP_IMM);
      2'd2:    send_f(OP_BNE, F3_BNE, BRANCH);
      default: send_f(OP_JAL, 3'(rand_bits(3)), JAL);
    endcase
    if (k == 5) idle();
  end
  finish_test("illegal_flow");
endtask

// ==== sim/tb_decode_stage.sv ====
/* decode stage testbench */

module tb_decode_stage
  import rv_decode_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // watchdog budget, 10 ns per instruction plus margin
  localparam int NUM_TESTS  = 6;
  localparam int MAX_INSTS  = 48;
  localparam int TIMEOUT_NS = NUM_TESTS * MAX_INSTS * 10 + 500;

  logic              clk;
  logic              rst;
  logic              i_valid;
  logic [INST_W-1:0] i_inst;
  logic [XLEN-1:0]   i_pc;
  logic [XLEN-1:0]   i_rs1_data;
  logic [XLEN-1:0]   i_rs2_data;
  logic [RIDX_W-1:0] o_rs1;
  logic [RIDX_W-1:0] o_rs2;
  logic              o_rs1_ren;
  logic              o_rs2_ren;
  logic              o_valid;
  inst_op_e          o_op;
  logic [RIDX_W-1:0] o_rd;
  logic              o_rd_wen;
  logic [XLEN-1:0]   o_op1;
  logic [XLEN-1:0]   o_op2;
  logic [XLEN-1:0]   o_op3;
  logic [XLEN-1:0]   o_imm;

  // expected bundle of the instruction sent one cycle earlier
  logic              pend_act = 1'b0;
  logic              pend_valid;
  string             pend_tag;
  inst_op_e          pend_op;
  logic [RIDX_W-1:0] pend_rd;
  logic              pend_wen;
  logic [XLEN-1:0]   pend_op1;
  logic [XLEN-1:0]   pend_op2;
  logic [XLEN-1:0]   pend_op3;
  logic [XLEN-1:0]   pend_imm;

  // random source and tallies
  logic [31:0] lfsr = 32'hd8f4_c388;
  int          errs = 0;
  int          checks = 0;
  int          tests_done = 0;
  int          test_errs = 0;
  int          test_insts = 0;

  decode_stage u_decode_stage (
    .clk        (clk),
    .rst        (rst),
    .i_valid    (i_valid),
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_rs1      (o_rs1),
    .o_rs2      (o_rs2),
    .o_rs1_ren  (o_rs1_ren),
    .o_rs2_ren  (o_rs2_ren),
    .o_valid    (o_valid),
    .o_op       (o_op),
    .o_rd       (o_rd),
    .o_rd_wen   (o_rd_wen),
    .o_op1      (o_op1),
    .o_op2      (o_op2),
    .o_op3      (o_op3),
    .o_imm      (o_imm)
  );

  `include "tb_decode_tasks.svh"

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: tests still running after %0d ns, stopping", TIMEOUT_NS);
    $display("Simulation FAILED");
    $finish;
  end

  // test sequence
  initial begin
    rst        <= 1'b1;
    i_valid    <= 1'b0;
    i_inst     <= '0;
    i_pc       <= '0;
    i_rs1_data <= '0;
    i_rs2_data <= '0;
    test_reset();
    test_reg_ops();
    test_imm_ops();
    test_stores();
    test_control();
    test_illegal_flow();
    $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errs);
    if (errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/decode_stage.sv ====
/* rv64i decode stage */

module decode_stage import rv_decode_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_valid,
  input  logic [INST_W-1:0] i_inst,
  input  logic [XLEN-1:0]   i_pc,
  input  logic [XLEN-1:0]   i_rs1_data,
  input  logic [XLEN-1:0]   i_rs2_data,
  // regfile read side in the same cycle
  output logic [RIDX_W-1:0] o_rs1,
  output logic [RIDX_W-1:0] o_rs2,
  output logic              o_rs1_ren,
  output logic              o_rs2_ren,
  // bundle to execute one cycle later
  output logic              o_valid,
  output inst_op_e          o_op,
  output logic [RIDX_W-1:0] o_rd,
  output logic              o_rd_wen,
  output logic [XLEN-1:0]   o_op1,
  output logic [XLEN-1:0]   o_op2,
  output logic [XLEN-1:0]   o_op3,
  output logic [XLEN-1:0]   o_imm
);

  inst_op_e          dec_op;
  inst_fmt_e         dec_fmt;
  logic [RIDX_W-1:0] dec_rd;
  logic              dec_rd_wen;
  logic [XLEN-1:0]   dec_imm;
  logic [XLEN-1:0]   dec_op1;
  logic [XLEN-1:0]   dec_op2;
  logic [XLEN-1:0]   dec_op3;

  // op, format, register fields
  inst_classify u_inst_classify (
    .i_inst    (i_inst),
    .o_op      (dec_op),
    .o_fmt     (dec_fmt),
    .o_rs1     (o_rs1),
    .o_rs2     (o_rs2),
    .o_rs1_ren (o_rs1_ren),
    .o_rs2_ren (o_rs2_ren),
    .o_rd      (dec_rd),
    .o_rd_wen  (dec_rd_wen)
  );

  // format immediate
  imm_gen u_imm_gen (
    .i_inst (i_inst),
    .i_fmt  (dec_fmt),
    .o_imm  (dec_imm)
  );

  // rs data arrives combinationally this cycle
  operand_select u_operand_select (
    .i_op       (dec_op),
    .i_fmt      (dec_fmt),
    .i_inst     (i_inst),
    .i_imm      (dec_imm),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_op1      (dec_op1),
    .o_op2      (dec_op2),
    .o_op3      (dec_op3)
  );

  // decode to execute register
  // loads every cycle and never stalls
  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid  <= 1'b0;
      o_op     <= OP_ILLEGAL;
      o_rd     <= '0;
      o_rd_wen <= 1'b0;
      o_op1    <= '0;
      o_op2    <= '0;
      o_op3    <= '0;
      o_imm    <= '0;
    end else begin
      o_valid  <= i_valid;
      o_op     <= dec_op;
      o_rd     <= dec_rd;
      // bubble never writes back
      o_rd_wen <= dec_rd_wen & i_valid;
      o_op1    <= dec_op1;
      o_op2    <= dec_op2;
      o_op3    <= dec_op3;
      o_imm    <= dec_imm;
    end
  end

  // bundle empty right after reset
  a_rst_clears_valid: assert property (@(posedge clk) rst |=> !o_valid)
    else $error("o_valid high in the cycle after reset");

endmodule

// ==== hdl/operand_select.sv ====
/* operand select */

module operand_select import rv_decode_pkg::*; (
  input  inst_op_e          i_op,
  input  inst_fmt_e         i_fmt,
  input  logic [INST_W-1:0] i_inst,
  input  logic [XLEN-1:0]   i_imm,
  input  logic [XLEN-1:0]   i_pc,
  input  logic [XLEN-1:0]   i_rs1_data,
  input  logic [XLEN-1:0]   i_rs2_data,
  output logic [XLEN-1:0]   o_op1,
  output logic [XLEN-1:0]   o_op2,
  output logic [XLEN-1:0]   o_op3
);

  logic [XLEN-1:0] shamt;
  logic            is_shift_imm;
  logic [XLEN-1:0] pc_plus_imm;
  logic [XLEN-1:0] pc_plus_4;

  // 6-bit shamt, zero extended
  assign shamt = {{(XLEN-6){1'b0}}, i_inst[25:20]};

  // all shift-immediate forms, 64 and 32 bit
  assign is_shift_imm = i_op inside {OP_SLLI, OP_SRLI, OP_SRAI,
                                     OP_SLLIW, OP_SRLIW, OP_SRAIW};

  // branch/jal target and link address
  assign pc_plus_imm = i_pc + i_imm;
  assign pc_plus_4   = i_pc + XLEN'(4);

  // op1
  // lui/auipc put the upper imm here
  always_comb begin
    case (i_fmt)
      FMT_R, FMT_I, FMT_S, FMT_B: o_op1 = i_rs1_data;
      FMT_U:   o_op1 = i_imm;
      FMT_J:   o_op1 = i_pc;
      default: o_op1 = '0;
    endcase
  end

  // op2
  always_comb begin
    case (i_fmt)
      FMT_R, FMT_S, FMT_B: o_op2 = i_rs2_data;
      FMT_I: begin
        if (is_shift_imm) begin
          o_op2 = shamt;
        end else begin
          o_op2 = i_imm;
        end
      end
      // auipc adds pc, lui ignores it downstream
      FMT_U:   o_op2 = i_pc;
      // jal link increment
      FMT_J:   o_op2 = XLEN'(4);
      default: o_op2 = '0;
    endcase
  end

  // op3
  // target for B/J, return address for jalr
  always_comb begin
    case (i_fmt)
      FMT_B, FMT_J: o_op3 = pc_plus_imm;
      FMT_I: begin
        if (i_op == OP_JALR) begin
          o_op3 = pc_plus_4;
        end else begin
          o_op3 = '0;
        end
      end
      default: o_op3 = '0;
    endcase
  end

endmodule

// ==== hdl/imm_gen.sv ====
/* immediate generator */

module imm_gen import rv_decode_pkg::*; (
  input  logic [INST_W-1:0] i_inst,
  input  inst_fmt_e         i_fmt,
  output logic [XLEN-1:0]   o_imm
);

  logic sign;

  // every format signs from bit 31
  assign sign = i_inst[31];

  always_comb begin
    case (i_fmt)
      FMT_I: o_imm = {{(XLEN-12){sign}}, i_inst[31:20]};
      // split field, upper and lower halves
      FMT_S: o_imm = {{(XLEN-12){sign}}, i_inst[31:25], i_inst[11:7]};
      // halfword offset, bit 0 implied zero
      FMT_B: begin
        o_imm = {{(XLEN-12){sign}}, i_inst[7], i_inst[30:25],
                 i_inst[11:8], 1'b0};
      end
      // upper 20, low 12 cleared
      FMT_U: o_imm = {{(XLEN-32){sign}}, i_inst[31:12], 12'b0};
      FMT_J: begin
        o_imm = {{(XLEN-20){sign}}, i_inst[19:12], i_inst[20],
                 i_inst[30:21], 1'b0};
      end
      // R and none carry no immediate
      default: o_imm = '0;
    endcase
  end

  // pc-relative offsets stay halfword aligned
  always_comb begin
    assert final (!(i_fmt inside {FMT_B, FMT_J}) || !o_imm[0])
      else $error("branch or jump offset not halfword aligned");
  end

endmodule

// ==== hdl/inst_classify.sv ====
/* instruction classifier */

module inst_classify import rv_decode_pkg::*; (
  input  logic [INST_W-1:0] i_inst,
  output inst_op_e          o_op,
  output inst_fmt_e         o_fmt,
  output logic [RIDX_W-1:0] o_rs1,
  output logic [RIDX_W-1:0] o_rs2,
  output logic              o_rs1_ren,
  output logic              o_rs2_ren,
  output logic [RIDX_W-1:0] o_rd,
  output logic              o_rd_wen
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;

  // raw fields
  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign funct6 = i_inst[31:26];

  // anything unmatched stays illegal
  always_comb begin
    o_op = OP_ILLEGAL;
    case (opcode)
      LUI:   o_op = OP_LUI;
      AUIPC: o_op = OP_AUIPC;
      JAL:   o_op = OP_JAL;
      JALR: begin
        if (funct3 == F3_JALR) o_op = OP_JALR;
      end
      BRANCH: begin
        case (funct3)
          F3_BEQ:  o_op = OP_BEQ;
          F3_BNE:  o_op = OP_BNE;
          F3_BLT:  o_op = OP_BLT;
          F3_BGE:  o_op = OP_BGE;
          F3_BLTU: o_op = OP_BLTU;
          F3_BGEU: o_op = OP_BGEU;
          default: o_op = OP_ILLEGAL;
        endcase
      end
      LOAD: begin
        // funct3 3'b111 unused
        case (funct3)
          F3_LB:   o_op = OP_LB;
          F3_LH:   o_op = OP_LH;
          F3_LW:   o_op = OP_LW;
          F3_LD:   o_op = OP_LD;
          F3_LBU:  o_op = OP_LBU;
          F3_LHU:  o_op = OP_LHU;
          F3_LWU:  o_op = OP_LWU;
          default: o_op = OP_ILLEGAL;
        endcase
      end
      STORE: begin
        case (funct3)
          F3_SB:   o_op = OP_SB;
          F3_SH:   o_op = OP_SH;
          F3_SW:   o_op = OP_SW;
          F3_SD:   o_op = OP_SD;
          default: o_op = OP_ILLEGAL;
        endcase
      end
      OP_IMM: begin
        case (funct3)
          F3_ADD:  o_op = OP_ADDI;
          F3_SLT:  o_op = OP_SLTI;
          F3_SLTU: o_op = OP_SLTIU;
          F3_XOR:  o_op = OP_XORI;
          F3_OR:   o_op = OP_ORI;
          F3_AND:  o_op = OP_ANDI;
          // shifts check the upper six bits only
          F3_SLL: begin
            if (funct6 == F6_SHIFT) o_op = OP_SLLI;
          end
          F3_SRL: begin
            if (funct6 == F6_SHIFT) o_op = OP_SRLI;
            else if (funct6 == F6_SRAI) o_op = OP_SRAI;
          end
          default: o_op = OP_ILLEGAL;
        endcase
      end
      OP_IMM_32: begin
        // word shifts need full funct7 so shamt[5] stays zero
        case (funct3)
          F3_ADD: o_op = OP_ADDIW;
          F3_SLL: begin
            if (funct7 == F7_BASE) o_op = OP_SLLIW;
          end
          F3_SRL: begin
            if (funct7 == F7_BASE) o_op = OP_SRLIW;
            else if (funct7 == F7_SRA) o_op = OP_SRAIW;
          end
          default: o_op = OP_ILLEGAL;
        endcase
      end
      OP: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            F3_ADD:  o_op = OP_ADD;
            F3_SLL:  o_op = OP_SLL;
            F3_SLT:  o_op = OP_SLT;
            F3_SLTU: o_op = OP_SLTU;
            F3_XOR:  o_op = OP_XOR;
            F3_SRL:  o_op = OP_SRL;
            F3_OR:   o_op = OP_OR;
            F3_AND:  o_op = OP_AND;
            default: o_op = OP_ILLEGAL;
          endcase
        end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
          o_op = OP_SUB;
        end else if (funct7 == F7_SRA && funct3 == F3_SRL) begin
          o_op = OP_SRA;
        end
      end
      OP_32: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            F3_ADD:  o_op = OP_ADDW;
            F3_SLL:  o_op = OP_SLLW;
            F3_SRL:  o_op = OP_SRLW;
            default: o_op = OP_ILLEGAL;
          endcase
        end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
          o_op = OP_SUBW;
        end else if (funct7 == F7_SRA && funct3 == F3_SRL) begin
          o_op = OP_SRAW;
        end
      end
      default: o_op = OP_ILLEGAL;
    endcase
  end

  // format ranges follow the enum grouping
  always_comb begin
    case (o_op) inside
      [OP_LUI:OP_AUIPC]: o_fmt = FMT_U;
      OP_JAL:            o_fmt = FMT_J;
      [OP_JALR:OP_SRAIW]: o_fmt = FMT_I;
      [OP_BEQ:OP_BGEU]:  o_fmt = FMT_B;
      [OP_SB:OP_SD]:     o_fmt = FMT_S;
      [OP_ADD:OP_SRAW]:  o_fmt = FMT_R;
      default:           o_fmt = FMT_NONE;
    endcase
  end

  // register port enables
  assign o_rs1_ren = o_fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
  assign o_rs2_ren = o_fmt inside {FMT_R, FMT_S, FMT_B};
  assign o_rd_wen  = o_fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};

  // indices zeroed when unused
  assign o_rs1 = o_rs1_ren ? i_inst[19:15] : '0;
  assign o_rs2 = o_rs2_ren ? i_inst[24:20] : '0;
  assign o_rd  = o_rd_wen  ? i_inst[11:7]  : '0;

  // illegal op must not reach the register file
  // B and S opcodes carry no rd field
  always_comb begin
    assert final (o_op != OP_ILLEGAL || !(o_rs1_ren || o_rs2_ren || o_rd_wen))
      else $error("illegal instruction raised a register enable");
    assert final (!o_rd_wen || !(opcode inside {BRANCH, STORE}))
      else $error("rd write on a format without rd");
  end

endmodule

// ==== hdl/rv_decode_pkg.sv ====
/* rv64i decode definitions */

package rv_decode_pkg;

  // datapath and field widths
  localparam int XLEN   = 64;
  localparam int INST_W = 32;
  localparam int RIDX_W = 5;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    LUI       = 7'b0110111,
    AUIPC     = 7'b0010111,
    JAL       = 7'b1101111,
    JALR      = 7'b1100111,
    BRANCH    = 7'b1100011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP        = 7'b0110011,
    OP_IMM_32 = 7'b0011011,
    OP_32     = 7'b0111011
  } opcode_e;

  // instruction formats
  typedef enum logic [2:0] {
    FMT_NONE = 3'd0,
    FMT_R    = 3'd1,
    FMT_I    = 3'd2,
    FMT_S    = 3'd3,
    FMT_B    = 3'd4,
    FMT_U    = 3'd5,
    FMT_J    = 3'd6
  } inst_fmt_e;

  // one value per instruction
  // grouped by format, inst_classify relies on this order for its ranges
  typedef enum logic [5:0] {
    OP_LUI, OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_SB, OP_SH, OP_SW, OP_SD,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
    OP_ILLEGAL
  } inst_op_e;

  // funct3, control flow
  localparam logic [2:0] F3_JALR = 3'b000;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct3, memory
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LD  = 3'b011;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;
  localparam logic [2:0] F3_LWU = 3'b110;
  localparam logic [2:0] F3_SB  = 3'b000;
  localparam logic [2:0] F3_SH  = 3'b001;
  localparam logic [2:0] F3_SW  = 3'b010;
  localparam logic [2:0] F3_SD  = 3'b011;

  // funct3, alu, shared by reg and imm forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 for reg ops and word shifts
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;
  localparam logic [6:0] F7_SRA  = 7'b0100000;

  // rv64 shift-imm, inst[25] belongs to the 6-bit shamt
  localparam logic [5:0] F6_SHIFT = 6'b000000;
  localparam logic [5:0] F6_SRAI  = 6'b010000;

endpackage
